// File: include/vdec_config.svh
//==============================
// vector decode configuration
// register, element, scalar and
// element index widths
//==============================
`ifndef VDEC_CONFIG_SVH
`define VDEC_CONFIG_SVH

// bits in one vector register
`define VDEC_VLEN 128

// element width seen by the lanes
`define VDEC_ELEN 32

// scalar register width
`define VDEC_XLEN 32

// element index width, also carries vl and vstart
`define VDEC_OFFSET_W 8

`endif

// File: design/vdec_types_pkg.sv
//==============================
// vector decode types
// field widths and decode enums
//==============================
`include "vdec_config.svh"

package vdec_types_pkg;

  // raw instruction word from fetch
  typedef logic [31:0] instr_t;
  typedef logic [`VDEC_XLEN-1:0] xlen_t;
  typedef logic [`VDEC_ELEN-1:0] elem_t;
  // element index, vl and vstart
  typedef logic [`VDEC_OFFSET_W-1:0] offset_t;
  typedef logic [4:0] vreg_t;

  // major opcode of all vector arithmetic
  typedef enum logic [6:0] {
    OPC_OP_V = 7'b1010111
  } opcode_t;

  // integer operand forms
  typedef enum logic [2:0] {
    F3_OPIVV = 3'b000,
    F3_OPIVI = 3'b011,
    F3_OPIVX = 3'b100
  } funct3_t;

  typedef enum logic [5:0] {
    F6_VADD       = 6'b000000,
    F6_VSUB       = 6'b000010,
    F6_VRGATHER   = 6'b001100,
    F6_VSLIDEUP   = 6'b001110,
    F6_VSLIDEDOWN = 6'b001111
  } funct6_t;

  // operation class handed to execute
  typedef enum logic [2:0] {
    VOP_ADD,
    VOP_SUB,
    VOP_SLIDEUP,
    VOP_SLIDEDOWN,
    VOP_RGATHER,
    VOP_ILLEGAL
  } vop_t;

  typedef enum logic [1:0] {
    SRC_VV,
    SRC_VX,
    SRC_VI
  } src_kind_t;

  // how vs2 read offsets are formed
  typedef enum logic [1:0] {
    VS2_NORMAL,
    VS2_IDX_PLUS_SHIFT,
    VS2_FROM_VS1
  } vs2_src_t;

  typedef enum logic {
    VD_NORMAL,
    VD_IDX_PLUS_SHIFT
  } vd_src_t;

endpackage

// File: design/vdec_bus_pkg.sv
//==============================
// vector decode buses
// structs between the decode
// blocks and their neighbours
//==============================

package vdec_bus_pkg;

  // csr values seen by decode
  typedef struct packed {
    vdec_types_pkg::offset_t vl;
    vdec_types_pkg::offset_t vstart;
  } vcsr_t;

  typedef struct packed {
    logic stall_dec;
    logic flush_dec;
  } hazard_ctrl_t;

  // decoded instruction held for the whole walk
  typedef struct packed {
    vdec_types_pkg::vop_t      op;
    vdec_types_pkg::vreg_t     vs1;
    vdec_types_pkg::vreg_t     vs2;
    vdec_types_pkg::vreg_t     vd;
    logic                      vm;
    logic [4:0]                imm5;
    vdec_types_pkg::src_kind_t src;
    vdec_types_pkg::vs2_src_t  vs2_src;
    vdec_types_pkg::vd_src_t   vd_src;
    logic                      active;
  } vop_ctrl_t;

  // two lanes per read where the vd offsets double as v0 lookup
  typedef struct packed {
    vdec_types_pkg::vreg_t   vs1;
    vdec_types_pkg::vreg_t   vs2;
    vdec_types_pkg::vreg_t   vd;
    vdec_types_pkg::offset_t vs1_offset0;
    vdec_types_pkg::offset_t vs1_offset1;
    vdec_types_pkg::offset_t vs2_offset0;
    vdec_types_pkg::offset_t vs2_offset1;
    vdec_types_pkg::offset_t woffset0;
    vdec_types_pkg::offset_t woffset1;
  } rf_read_req_t;

  typedef struct packed {
    vdec_types_pkg::elem_t vs1_data0;
    vdec_types_pkg::elem_t vs1_data1;
    vdec_types_pkg::elem_t vs2_data0;
    vdec_types_pkg::elem_t vs2_data1;
    logic                  v0_mask0;
    logic                  v0_mask1;
  } rf_read_rsp_t;

  // one micro-op toward execute
  typedef struct packed {
    logic                    valid;
    vdec_types_pkg::vop_t    aluop;
    vdec_types_pkg::vreg_t   vd;
    vdec_types_pkg::offset_t woffset0;
    vdec_types_pkg::offset_t woffset1;
    logic                    wen0;
    logic                    wen1;
    vdec_types_pkg::elem_t   vs1_lane0;
    vdec_types_pkg::elem_t   vs1_lane1;
    vdec_types_pkg::elem_t   vs2_lane0;
    vdec_types_pkg::elem_t   vs2_lane1;
    vdec_types_pkg::xlen_t   scalar;
    logic                    decode_done;
  } decode_exec_t;

endpackage

// File: design/vector_op_decoder.sv
//==============================
// vector op decoder
// holds one instruction and turns
// it into the control struct
//==============================
`timescale 1ns/1ps

module vector_op_decoder (
  input  logic                       CLK,
  input  logic                       nRST,
  input  vdec_types_pkg::instr_t     instr,
  input  logic                       instr_valid,
  output logic                       instr_ready,
  input  logic                       last,
  input  logic                       busy,
  input  vdec_bus_pkg::hazard_ctrl_t hz,
  output vdec_bus_pkg::vop_ctrl_t    ctrl
);

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_DECODE,
    DEC_ISSUE
  } dec_state_t;

  dec_state_t              state_q;
  vdec_types_pkg::instr_t  instr_q;
  vdec_bus_pkg::vop_ctrl_t ctrl_q;
  vdec_bus_pkg::vop_ctrl_t dec;
  vdec_types_pkg::opcode_t opcode;
  vdec_types_pkg::funct3_t funct3;
  vdec_types_pkg::funct6_t funct6;
  logic                    f3_ok;
  logic                    accept;

  assign instr_ready = ~busy & (state_q == DEC_IDLE);
  assign accept      = instr_valid & instr_ready;

  assign opcode = vdec_types_pkg::opcode_t'(instr_q[6:0]);
  assign funct3 = vdec_types_pkg::funct3_t'(instr_q[14:12]);
  assign funct6 = vdec_types_pkg::funct6_t'(instr_q[31:26]);
  assign f3_ok  = (funct3 == vdec_types_pkg::F3_OPIVV) |
                  (funct3 == vdec_types_pkg::F3_OPIVX) |
                  (funct3 == vdec_types_pkg::F3_OPIVI);

  always_comb begin
    dec         = '0;
    dec.vs2     = instr_q[24:20];
    dec.vs1     = instr_q[19:15];
    dec.imm5    = instr_q[19:15];
    dec.vd      = instr_q[11:7];
    dec.vm      = instr_q[25];
    dec.active  = 1'b1;
    dec.op      = vdec_types_pkg::VOP_ILLEGAL;
    dec.vs2_src = vdec_types_pkg::VS2_NORMAL;
    dec.vd_src  = vdec_types_pkg::VD_NORMAL;
    case (funct3)
      vdec_types_pkg::F3_OPIVX: dec.src = vdec_types_pkg::SRC_VX;
      vdec_types_pkg::F3_OPIVI: dec.src = vdec_types_pkg::SRC_VI;
      default:                  dec.src = vdec_types_pkg::SRC_VV;
    endcase
    // only the integer forms of the kept ops are legal
    if ((opcode == vdec_types_pkg::OPC_OP_V) && f3_ok) begin
      case (funct6)
        vdec_types_pkg::F6_VADD: begin
          dec.op = vdec_types_pkg::VOP_ADD;
        end
        vdec_types_pkg::F6_VSUB: begin
          if (funct3 != vdec_types_pkg::F3_OPIVI) begin
            dec.op = vdec_types_pkg::VOP_SUB;
          end
        end
        vdec_types_pkg::F6_VSLIDEUP: begin
          if (funct3 != vdec_types_pkg::F3_OPIVV) begin
            dec.op     = vdec_types_pkg::VOP_SLIDEUP;
            dec.vd_src = vdec_types_pkg::VD_IDX_PLUS_SHIFT;
          end
        end
        vdec_types_pkg::F6_VSLIDEDOWN: begin
          if (funct3 != vdec_types_pkg::F3_OPIVV) begin
            dec.op      = vdec_types_pkg::VOP_SLIDEDOWN;
            dec.vs2_src = vdec_types_pkg::VS2_IDX_PLUS_SHIFT;
          end
        end
        vdec_types_pkg::F6_VRGATHER: begin
          if (funct3 == vdec_types_pkg::F3_OPIVV) begin
            dec.op      = vdec_types_pkg::VOP_RGATHER;
            dec.vs2_src = vdec_types_pkg::VS2_FROM_VS1;
          end
        end
        default: begin
          dec.op = vdec_types_pkg::VOP_ILLEGAL;
        end
      endcase
    end
  end

  // instruction word only
  always_ff @(posedge CLK) begin
    if (accept) begin
      instr_q <= instr;
    end
  end

  // one cycle to decode, then issue until the last pair leaves
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q <= DEC_IDLE;
      ctrl_q  <= '0;
    end else begin
      case (state_q)
        DEC_IDLE: begin
          if (accept) begin
            state_q <= DEC_DECODE;
          end
        end
        DEC_DECODE: begin
          if (hz.flush_dec) begin
            state_q <= DEC_IDLE;
          end else begin
            state_q <= DEC_ISSUE;
            ctrl_q  <= dec;
          end
        end
        DEC_ISSUE: begin
          if (hz.flush_dec || (last && !hz.stall_dec)) begin
            state_q       <= DEC_IDLE;
            ctrl_q.active <= 1'b0;
          end
        end
        default: begin
          state_q       <= DEC_IDLE;
          ctrl_q.active <= 1'b0;
        end
      endcase
    end
  end

  assign ctrl = ctrl_q;

endmodule

// File: design/element_counter.sv
//==============================
// element counter
// walks element pairs from
// vstart up to vl
//==============================
`timescale 1ns/1ps
`include "vdec_config.svh"

module element_counter (
  input  logic                       CLK,
  input  logic                       nRST,
  input  vdec_bus_pkg::vop_ctrl_t    ctrl,
  input  vdec_bus_pkg::vcsr_t        csr,
  input  vdec_bus_pkg::hazard_ctrl_t hz,
  output vdec_types_pkg::offset_t    idx,
  output logic                       last,
  output logic                       busy
);

  vdec_types_pkg::offset_t idx_q;
  logic [`VDEC_OFFSET_W:0] idx_plus2;
  logic                    empty;

  // one extra bit so the compare survives wrap
  assign idx_plus2 = {1'b0, idx_q} + 2;

  // one micro-op still goes out with nothing to walk
  assign empty = (csr.vstart >= csr.vl);

  assign last = ctrl.active & ((idx_plus2 >= {1'b0, csr.vl}) | empty |
                               (ctrl.op == vdec_types_pkg::VOP_ILLEGAL));
  assign busy = ctrl.active;
  assign idx  = idx_q;

  // idle counter tracks vstart so the first pair is ready at issue
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      idx_q <= '0;
    end else if (!ctrl.active) begin
      idx_q <= csr.vstart;
    end else if (!hz.stall_dec) begin
      idx_q <= idx_plus2[`VDEC_OFFSET_W-1:0];
    end
  end

  // vl and vstart have to hold still while a walk is in flight
  a_idx_in_range: assert property (@(posedge CLK) disable iff (!nRST)
    (busy && !empty) |-> ({1'b0, idx_q} <= ({1'b0, csr.vl} + 1)))
    else $error("element index ran past vl");

  // largest legal vl is VLEN, at 8-bit elements and lmul 8
  a_vl_fits: assert property (@(posedge CLK) disable iff (!nRST)
    busy |-> (csr.vl <= `VDEC_VLEN))
    else $error("vl exceeds VLMAX");

endmodule

// File: design/operand_offset_gen.sv
//==============================
// operand offset generator
// read and write offsets, masks
// and write enables per pair
//==============================
`timescale 1ns/1ps
`include "vdec_config.svh"

module operand_offset_gen (
  input  vdec_bus_pkg::vop_ctrl_t    ctrl,
  input  vdec_types_pkg::offset_t    idx,
  input  vdec_types_pkg::xlen_t      xs1,
  input  vdec_bus_pkg::vcsr_t        csr,
  output vdec_bus_pkg::rf_read_req_t rf_req,
  input  vdec_bus_pkg::rf_read_rsp_t rf_rsp,
  output vdec_bus_pkg::decode_exec_t lanes
);

  vdec_types_pkg::xlen_t shift;
  vdec_types_pkg::xlen_t scalar_op;
  logic [`VDEC_XLEN:0]   idx_w;
  logic [`VDEC_XLEN:0]   idx1_w;
  logic [`VDEC_XLEN:0]   slide_w;
  logic [`VDEC_XLEN:0]   slide1_w;
  logic [`VDEC_XLEN:0]   wr0_w;
  logic [`VDEC_XLEN:0]   wr1_w;
  logic [`VDEC_XLEN:0]   vl_w;
  logic [`VDEC_XLEN:0]   vstart_w;
  logic                  mask0;
  logic                  mask1;
  logic                  legal;
  logic                  is_slide;

  // offsets are formed wide so a large xs1 cannot wrap into range
  assign idx_w    = {{(`VDEC_XLEN + 1 - `VDEC_OFFSET_W){1'b0}}, idx};
  assign vl_w     = {{(`VDEC_XLEN + 1 - `VDEC_OFFSET_W){1'b0}}, csr.vl};
  assign vstart_w = {{(`VDEC_XLEN + 1 - `VDEC_OFFSET_W){1'b0}}, csr.vstart};

  always_comb begin
    case (ctrl.src)
      vdec_types_pkg::SRC_VX: begin
        shift     = xs1;
        scalar_op = xs1;
      end
      vdec_types_pkg::SRC_VI: begin
        // slides take uimm5, arithmetic takes simm5
        shift     = {{(`VDEC_XLEN - 5){1'b0}}, ctrl.imm5};
        scalar_op = {{(`VDEC_XLEN - 5){ctrl.imm5[4]}}, ctrl.imm5};
      end
      default: begin
        shift     = '0;
        scalar_op = '0;
      end
    endcase
  end

  assign idx1_w   = idx_w + 1;
  assign slide_w  = idx_w + {1'b0, shift};
  assign slide1_w = slide_w + 1;

  assign wr0_w = (ctrl.vd_src == vdec_types_pkg::VD_IDX_PLUS_SHIFT) ? slide_w : idx_w;
  assign wr1_w = (ctrl.vd_src == vdec_types_pkg::VD_IDX_PLUS_SHIFT) ? slide1_w : idx1_w;

  assign is_slide = (ctrl.op == vdec_types_pkg::VOP_SLIDEUP) |
                    (ctrl.op == vdec_types_pkg::VOP_SLIDEDOWN);
  assign legal    = (ctrl.op != vdec_types_pkg::VOP_ILLEGAL);

  // vm set means unmasked
  assign mask0 = ctrl.vm | rf_rsp.v0_mask0;
  assign mask1 = ctrl.vm | rf_rsp.v0_mask1;

  always_comb begin
    rf_req             = '0;
    rf_req.vs1         = ctrl.vs1;
    rf_req.vs2         = ctrl.vs2;
    rf_req.vd          = ctrl.vd;
    rf_req.vs1_offset0 = idx;
    rf_req.vs1_offset1 = idx1_w[`VDEC_OFFSET_W-1:0];
    rf_req.woffset0    = wr0_w[`VDEC_OFFSET_W-1:0];
    rf_req.woffset1    = wr1_w[`VDEC_OFFSET_W-1:0];
    case (ctrl.vs2_src)
      vdec_types_pkg::VS2_IDX_PLUS_SHIFT: begin
        rf_req.vs2_offset0 = slide_w[`VDEC_OFFSET_W-1:0];
        rf_req.vs2_offset1 = slide1_w[`VDEC_OFFSET_W-1:0];
      end
      vdec_types_pkg::VS2_FROM_VS1: begin
        // gather indices come straight from the vs1 read
        rf_req.vs2_offset0 = rf_rsp.vs1_data0[`VDEC_OFFSET_W-1:0];
        rf_req.vs2_offset1 = rf_rsp.vs1_data1[`VDEC_OFFSET_W-1:0];
      end
      default: begin
        rf_req.vs2_offset0 = idx;
        rf_req.vs2_offset1 = idx1_w[`VDEC_OFFSET_W-1:0];
      end
    endcase
  end

  always_comb begin
    lanes           = '0;
    lanes.aluop     = ctrl.op;
    lanes.vd        = ctrl.vd;
    lanes.woffset0  = wr0_w[`VDEC_OFFSET_W-1:0];
    lanes.woffset1  = wr1_w[`VDEC_OFFSET_W-1:0];
    lanes.wen0      = mask0 & (wr0_w < vl_w) & (wr0_w >= vstart_w) & legal;
    lanes.wen1      = mask1 & (wr1_w < vl_w) & (wr1_w >= vstart_w) & legal;
    lanes.vs2_lane0 = rf_rsp.vs2_data0;
    lanes.vs2_lane1 = rf_rsp.vs2_data1;
    lanes.scalar    = is_slide ? shift : scalar_op;
    case (ctrl.src)
      vdec_types_pkg::SRC_VX: begin
        lanes.vs1_lane0 = vdec_types_pkg::elem_t'(xs1);
        lanes.vs1_lane1 = vdec_types_pkg::elem_t'(xs1);
      end
      vdec_types_pkg::SRC_VI: begin
        lanes.vs1_lane0 = {{(`VDEC_ELEN - 5){ctrl.imm5[4]}}, ctrl.imm5};
        lanes.vs1_lane1 = {{(`VDEC_ELEN - 5){ctrl.imm5[4]}}, ctrl.imm5};
      end
      default: begin
        lanes.vs1_lane0 = rf_rsp.vs1_data0;
        lanes.vs1_lane1 = rf_rsp.vs1_data1;
      end
    endcase
  end

endmodule

// File: design/decode_execute_latch.sv
//==============================
// decode to execute register
// one micro-op, stall and flush
//==============================
`timescale 1ns/1ps

module decode_execute_latch (
  input  logic                       CLK,
  input  logic                       nRST,
  input  vdec_bus_pkg::hazard_ctrl_t hz,
  input  vdec_bus_pkg::vop_ctrl_t    ctrl,
  input  logic                       last,
  input  vdec_bus_pkg::decode_exec_t lanes,
  output vdec_bus_pkg::decode_exec_t ex
);

  vdec_bus_pkg::decode_exec_t uop;

  // lanes arrive without valid and done
  always_comb begin
    uop             = lanes;
    uop.valid       = ctrl.active;
    uop.decode_done = last;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ex <= '0;
    end else if (hz.flush_dec) begin
      ex <= '0;
    end else if (!hz.stall_dec) begin
      // idle cycles drain to an all-zero bubble
      if (ctrl.active) begin
        ex <= uop;
      end else begin
        ex <= '0;
      end
    end
  end

  // a flushed instruction must not leak a micro-op into execute
  // one edge later the decoder has dropped it as well
  a_flush_kills_ex: assert property (@(posedge CLK) disable iff (!nRST)
    (hz.flush_dec || $past(hz.flush_dec)) |=> !ex.valid)
    else $error("micro-op survived a flush");

endmodule

// File: design/rv32v_decode_stage.sv
//==============================
// rv32v decode stage
// decodes one vector op and
// issues two lanes per cycle
//==============================
`timescale 1ns/1ps

module rv32v_decode_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  vdec_types_pkg::instr_t     instr,
  input  logic                       instr_valid,
  output logic                       instr_ready,
  input  vdec_types_pkg::xlen_t      xs1,
  input  vdec_bus_pkg::vcsr_t        csr,
  input  vdec_bus_pkg::hazard_ctrl_t hz,
  output vdec_bus_pkg::rf_read_req_t rf_req,
  input  vdec_bus_pkg::rf_read_rsp_t rf_rsp,
  output vdec_bus_pkg::decode_exec_t ex
);

  vdec_bus_pkg::vop_ctrl_t    ctrl;
  vdec_types_pkg::offset_t    idx;
  logic                       last;
  logic                       busy;
  vdec_bus_pkg::decode_exec_t lanes;

  vector_op_decoder u_vector_op_decoder (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .last        (last),
    .busy        (busy),
    .hz          (hz),
    .ctrl        (ctrl)
  );

  element_counter u_element_counter (
    .CLK  (CLK),
    .nRST (nRST),
    .ctrl (ctrl),
    .csr  (csr),
    .hz   (hz),
    .idx  (idx),
    .last (last),
    .busy (busy)
  );

  // register file answers in the same cycle
  operand_offset_gen u_operand_offset_gen (
    .ctrl   (ctrl),
    .idx    (idx),
    .xs1    (xs1),
    .csr    (csr),
    .rf_req (rf_req),
    .rf_rsp (rf_rsp),
    .lanes  (lanes)
  );

  decode_execute_latch u_decode_execute_latch (
    .CLK   (CLK),
    .nRST  (nRST),
    .hz    (hz),
    .ctrl  (ctrl),
    .last  (last),
    .lanes (lanes),
    .ex    (ex)
  );

endmodule

// File: test/tb_decode_stage.sv
//==============================
// decode stage testbench
// register file model, reference
// micro-ops and a compare monitor
//==============================
`timescale 1ns/1ps

module tb_decode_stage;

  // funct6 and funct3 encodings from the vector spec
  localparam logic [5:0] F6_ADD       = 6'b000000;
  localparam logic [5:0] F6_SUB       = 6'b000010;
  localparam logic [5:0] F6_RGATHER   = 6'b001100;
  localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;
  localparam logic [2:0] F3_VV        = 3'b000;
  localparam logic [2:0] F3_VI        = 3'b011;
  localparam logic [2:0] F3_VX        = 3'b100;
  localparam int         WAIT_LIMIT   = 400;

  logic                       CLK = 1'b0;
  logic                       nRST;
  vdec_types_pkg::instr_t     instr;
  logic                       instr_valid;
  logic                       instr_ready;
  vdec_types_pkg::xlen_t      xs1;
  vdec_bus_pkg::vcsr_t        csr;
  vdec_bus_pkg::hazard_ctrl_t hz = '0;
  vdec_bus_pkg::rf_read_req_t rf_req;
  vdec_bus_pkg::rf_read_rsp_t rf_rsp;
  vdec_bus_pkg::decode_exec_t ex;

  vdec_bus_pkg::decode_exec_t exp_q[$];
  bit v0_bits [0:255];
  bit stall_en  = 1'b0;
  bit flush_req = 1'b0;
  bit flushed   = 1'b0;
  bit ready_mid = 1'b0;
  bit hung      = 1'b0;
  int err_count = 0;
  int uops_seen = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int errs_at_start;
  int uops_at_start;

  rv32v_decode_stage u_rv32v_decode_stage (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .xs1         (xs1),
    .csr         (csr),
    .hz          (hz),
    .rf_req      (rf_req),
    .rf_rsp      (rf_rsp),
    .ex          (ex)
  );

  always #20 CLK = ~CLK;

  // register file model where element o of register r holds r*256+o
  always_comb begin
    rf_rsp.vs1_data0 = 32'(rf_req.vs1) * 256 + 32'(rf_req.vs1_offset0);
    rf_rsp.vs1_data1 = 32'(rf_req.vs1) * 256 + 32'(rf_req.vs1_offset1);
    rf_rsp.vs2_data0 = 32'(rf_req.vs2) * 256 + 32'(rf_req.vs2_offset0);
    rf_rsp.vs2_data1 = 32'(rf_req.vs2) * 256 + 32'(rf_req.vs2_offset1);
    rf_rsp.v0_mask0  = v0_bits[rf_req.woffset0];
    rf_rsp.v0_mask1  = v0_bits[rf_req.woffset1];
  end

  // hazard unit stand-in
  always @(posedge CLK) begin
    hz.stall_dec <= stall_en && (($urandom % 3) == 0);
    hz.flush_dec <= flush_req;
  end

  function automatic int uop_count(input int vl, input int vstart);
    if (vstart >= vl) begin
      return 1;
    end
    return (vl - vstart + 1) / 2;
  endfunction

  function automatic logic [31:0] encode(input logic [5:0] f6, input logic [2:0] f3,
                                         input logic vm, input logic [4:0] vs2,
                                         input logic [4:0] rs1, input logic [4:0] vd);
    return {f6, vm, vs2, rs1, f3, vd, 7'b1010111};
  endfunction

  // expected micro-op k of one instruction
  function automatic vdec_bus_pkg::decode_exec_t ref_uop(
    input logic [5:0] f6, input logic [2:0] f3, input logic vm,
    input logic [4:0] vs2, input logic [4:0] rs1, input logic [4:0] vd,
    input logic [31:0] scal, input int vl, input int vstart, input int k);
    vdec_bus_pkg::decode_exec_t u;
    int          idx;
    int          shift;
    int          w0;
    int          w1;
    int          s0;
    int          s1;
    logic [31:0] simm;
    u     = '0;
    idx   = vstart + 2 * k;
    simm  = {{27{rs1[4]}}, rs1};
    shift = 0;
    if (f3 == F3_VX) begin
      shift = int'(scal);
    end else if (f3 == F3_VI) begin
      shift = int'(rs1);
    end
    case (f6)
      F6_SUB:       u.aluop = vdec_types_pkg::VOP_SUB;
      F6_SLIDEUP:   u.aluop = vdec_types_pkg::VOP_SLIDEUP;
      F6_SLIDEDOWN: u.aluop = vdec_types_pkg::VOP_SLIDEDOWN;
      F6_RGATHER:   u.aluop = vdec_types_pkg::VOP_RGATHER;
      default:      u.aluop = vdec_types_pkg::VOP_ADD;
    endcase
    w0 = (u.aluop == vdec_types_pkg::VOP_SLIDEUP) ? idx + shift : idx;
    w1 = w0 + 1;
    s0 = idx;
    s1 = idx + 1;
    if (u.aluop == vdec_types_pkg::VOP_SLIDEDOWN) begin
      s0 = idx + shift;
      s1 = s0 + 1;
    end else if (u.aluop == vdec_types_pkg::VOP_RGATHER) begin
      // gather index is the low byte of the vs1 element
      s0 = (int'(rs1) * 256 + idx % 256) % 256;
      s1 = (int'(rs1) * 256 + (idx + 1) % 256) % 256;
    end
    u.valid       = 1'b1;
    u.vd          = vd;
    u.woffset0    = 8'(w0);
    u.woffset1    = 8'(w1);
    u.wen0        = (vm | v0_bits[w0 % 256]) && (w0 < vl) && (w0 >= vstart);
    u.wen1        = (vm | v0_bits[w1 % 256]) && (w1 < vl) && (w1 >= vstart);
    u.vs2_lane0   = 32'(vs2) * 256 + 32'(s0 % 256);
    u.vs2_lane1   = 32'(vs2) * 256 + 32'(s1 % 256);
    u.decode_done = (k == uop_count(vl, vstart) - 1);
    case (f3)
      F3_VX: begin
        u.vs1_lane0 = scal;
        u.vs1_lane1 = scal;
        u.scalar    = scal;
      end
      F3_VI: begin
        u.vs1_lane0 = simm;
        u.vs1_lane1 = simm;
        // slides shift by the unsigned immediate
        u.scalar    = (f6 == F6_SLIDEUP || f6 == F6_SLIDEDOWN) ? {27'b0, rs1} : simm;
      end
      default: begin
        u.vs1_lane0 = 32'(rs1) * 256 + 32'(idx % 256);
        u.vs1_lane1 = 32'(rs1) * 256 + 32'((idx + 1) % 256);
      end
    endcase
    return u;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic compare_uop(input vdec_bus_pkg::decode_exec_t got,
                             input vdec_bus_pkg::decode_exec_t exp);
    check_val("ex.aluop", 32'(got.aluop), 32'(exp.aluop));
    check_val("ex.vd", 32'(got.vd), 32'(exp.vd));
    check_val("ex.woffset0", 32'(got.woffset0), 32'(exp.woffset0));
    check_val("ex.woffset1", 32'(got.woffset1), 32'(exp.woffset1));
    check_val("ex.wen0", 32'(got.wen0), 32'(exp.wen0));
    check_val("ex.wen1", 32'(got.wen1), 32'(exp.wen1));
    check_val("ex.vs1_lane0", got.vs1_lane0, exp.vs1_lane0);
    check_val("ex.vs1_lane1", got.vs1_lane1, exp.vs1_lane1);
    check_val("ex.vs2_lane0", got.vs2_lane0, exp.vs2_lane0);
    check_val("ex.vs2_lane1", got.vs2_lane1, exp.vs2_lane1);
    check_val("ex.scalar", got.scalar, exp.scalar);
    check_val("ex.decode_done", 32'(got.decode_done), 32'(exp.decode_done));
  endtask

  // mid-cycle monitor where a micro-op leaves ex when valid and not stalled
  always @(negedge CLK) begin
    ready_mid = instr_ready;
    if (nRST) begin
      if (hz.flush_dec) begin
        flushed = 1'b1;
        exp_q.delete();
      end else if (ex.valid && !hz.stall_dec) begin
        if (flushed) begin
          err_count++;
          $display("micro-op reached execute after a flush at t=%0t", $time);
        end else if (exp_q.size() == 0) begin
          err_count++;
          $display("unexpected extra micro-op at t=%0t", $time);
        end else begin
          // the next pair is already on the register file request
          if (exp_q.size() > 1) begin
            check_val("rf_req.vd", 32'(rf_req.vd), 32'(exp_q[1].vd));
            check_val("rf_req.woffset0", 32'(rf_req.woffset0), 32'(exp_q[1].woffset0));
            check_val("rf_req.woffset1", 32'(rf_req.woffset1), 32'(exp_q[1].woffset1));
          end
          compare_uop(ex, exp_q.pop_front());
          uops_seen++;
        end
      end
    end
  end

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(posedge CLK);
    while (!ready_mid && cycles < WAIT_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    if (!ready_mid) begin
      $display("timeout: instr_ready never went high");
      hung = 1'b1;
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || !ready_mid) && cycles < WAIT_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    if (exp_q.size() != 0 || !ready_mid) begin
      $display("timeout: %0d micro-ops never arrived", exp_q.size());
      hung = 1'b1;
    end
  endtask

  task automatic drive_instr(input logic [31:0] word, input logic [31:0] scal,
                             input int vl, input int vstart);
    instr       <= word;
    instr_valid <= 1'b1;
    xs1         <= scal;
    csr.vl      <= 8'(vl);
    csr.vstart  <= 8'(vstart);
    @(posedge CLK);
    instr_valid <= 1'b0;
  endtask

  task automatic issue_instr(
    input logic [5:0] f6, input logic [2:0] f3, input logic vm,
    input logic [4:0] vs2, input logic [4:0] rs1, input logic [4:0] vd,
    input logic [31:0] scal, input int vl, input int vstart);
    wait_ready();
    if (hung) begin
      return;
    end
    for (int k = 0; k < uop_count(vl, vstart); k++) begin
      exp_q.push_back(ref_uop(f6, f3, vm, vs2, rs1, vd, scal, vl, vstart, k));
    end
    drive_instr(encode(f6, f3, vm, vs2, rs1, vd), scal, vl, vstart);
    wait_drained();
  endtask

  function automatic logic [4:0] rand_reg();
    return 5'(1 + $urandom % 31);
  endfunction

  task automatic start_test();
    errs_at_start = err_count;
    uops_at_start = uops_seen;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count != errs_at_start || hung) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d micro-ops", name,
             (err_count != errs_at_start || hung) ? "FAIL" : "PASS",
             uops_seen - uops_at_start);
  endtask

  task automatic run_random_ops(input logic [5:0] f6, input logic [2:0] f3,
                                input logic vm, input logic [31:0] scal_max);
    int vl;
    int vstart;
    repeat (3) begin
      vl     = 1 + $urandom % 32;
      vstart = $urandom % vl;
      issue_instr(f6, f3, vm, rand_reg(), rand_reg(), rand_reg(),
                  (scal_max == 0) ? $urandom : $urandom % scal_max, vl, vstart);
    end
  endtask

  task automatic test_flush();
    int cycles;
    start_test();
    wait_ready();
    if (hung) begin
      finish_test("flush");
      return;
    end
    for (int k = 0; k < uop_count(40, 0); k++) begin
      exp_q.push_back(ref_uop(F6_ADD, F3_VV, 1'b1, 5'd2, 5'd3, 5'd4, 32'h0, 40, 0, k));
    end
    drive_instr(encode(F6_ADD, F3_VV, 1'b1, 5'd2, 5'd3, 5'd4), 32'h0, 40, 0);
    cycles = 0;
    while (exp_q.size() > 16 && cycles < WAIT_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    if (exp_q.size() > 16) begin
      $display("timeout: walk never reached the flush point");
      hung = 1'b1;
      finish_test("flush");
      return;
    end
    flush_req <= 1'b1;
    @(posedge CLK);
    flush_req <= 1'b0;
    cycles = 0;
    while (!(flushed && ready_mid) && cycles < WAIT_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    if (!(flushed && ready_mid)) begin
      $display("timeout: stage did not recover from a flush");
      hung = 1'b1;
      finish_test("flush");
      return;
    end
    // a few idle cycles in which no micro-op may appear
    repeat (3) @(posedge CLK);
    flushed = 1'b0;
    issue_instr(F6_ADD, F3_VV, 1'b1, 5'd5, 5'd6, 5'd7, 32'h0, 4, 0);
    finish_test("flush");
  endtask

  initial begin
    void'($urandom(6116));
    for (int i = 0; i < 256; i++) begin
      v0_bits[i] = 1'($urandom);
    end
    nRST        <= 1'b0;
    instr       <= '0;
    instr_valid <= 1'b0;
    xs1         <= '0;
    csr         <= '0;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    start_test();
    check_val("instr_ready", 32'(instr_ready), 32'd1);
    check_val("ex_any_bit", 32'(|ex), 32'd0);
    finish_test("reset");

    start_test();
    run_random_ops(F6_ADD, F3_VV, 1'b1, 32'd0);
    finish_test("vadd_vv");
    start_test();
    run_random_ops(F6_SUB, F3_VX, 1'b0, 32'd0);
    finish_test("vsub_vx_masked");
    start_test();
    run_random_ops(F6_SLIDEUP, F3_VX, 1'b1, 32'd12);
    run_random_ops(F6_SLIDEUP, F3_VI, 1'b0, 32'd0);
    run_random_ops(F6_SLIDEDOWN, F3_VX, 1'b0, 32'd12);
    run_random_ops(F6_SLIDEDOWN, F3_VI, 1'b1, 32'd0);
    finish_test("slides");
    start_test();
    run_random_ops(F6_RGATHER, F3_VV, 1'b0, 32'd0);
    finish_test("vrgather_vv");
    start_test();
    issue_instr(F6_ADD, F3_VV, 1'b1, 5'd1, 5'd2, 5'd3, 32'h0, 4, 6);
    finish_test("vstart_past_vl");
    start_test();
    stall_en <= 1'b1;
    run_random_ops(F6_ADD, F3_VV, 1'b0, 32'd0);
    run_random_ops(F6_SLIDEDOWN, F3_VX, 1'b1, 32'd10);
    stall_en <= 1'b0;
    finish_test("random_stall");
    if (!hung) begin
      test_flush();
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && !hung) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
design/vdec_types_pkg.sv
design/vdec_bus_pkg.sv
design/vector_op_decoder.sv
design/element_counter.sv
design/operand_offset_gen.sv
design/decode_execute_latch.sv
design/rv32v_decode_stage.sv
test/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_decode_stage -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Verification passed" sim.log; then
  echo "run.sh: simulation ok"
  exit 0
fi
echo "run.sh: simulation reported failure"
exit 1
